// ==== Makefile ====
# fetch unit simulation with Verilator

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_fetch -f build.f -Mdir obj_dir -o tb_fetch

run: compile
	./obj_dir/tb_fetch > sim.log 2>&1; cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed, see sim.log"; exit 1; fi
	@grep -q '>>> PASS' sim.log || { echo "no pass line in sim.log"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
source/fetch_pkg.sv
source/icache_l1.sv
source/fetch_ctrl.sv
source/fetch_top.sv
tb/imem_model.sv
tb/tb_fetch.sv

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  wire                      clk,
  input  wire                      rst,
  input  wire fetch_pkg::word_t    cache_inst_i,
  input  wire                      hit_i,
  input  wire                      idle_i,
  output fetch_pkg::addr_t         fetch_pc_o,
  output logic                     flush_o,
  output fetch_pkg::word_t         inst_o,
  output fetch_pkg::addr_t         pc_o,
  output logic                     valid_o,
  input  wire                      ready_i,
  input  wire                      pc_change_i,
  input  wire fetch_pkg::addr_t    npc_i,
  input  wire                      pc_retire_i,
  input  wire fetch_pkg::addr_t    retire_pc_i,
  output logic                     spec_o,
  output logic                     good_spec_o,
  output logic                     bad_spec_o
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_seq;

  // single-entry btb
  fetch_pkg::addr_t btb_q;
  logic             btb_valid_q;

  logic hazard_q;

  fetch_pkg::spec_state_t spec_q;
  fetch_pkg::spec_state_t spec_d;
  fetch_pkg::addr_t       pred_q;
  fetch_pkg::addr_t       fall_q;

  // pending restart after a bad speculation
  logic             redir_q;
  fetch_pkg::addr_t redir_pc_q;

  logic [6:0] opcode;
  logic       is_branch;
  logic       is_load;
  logic       is_store;
  logic       is_fence;

  logic             xfer;
  logic             start_spec;
  logic             spec_open;
  logic             resolve;
  logic             pred_match;
  logic             resolve_good;
  logic             resolve_bad;
  logic             release_hz;
  logic             resume;
  fetch_pkg::addr_t retire_next;

  // predecode
  assign opcode    = cache_inst_i[6:0];
  assign is_branch = (opcode == fetch_pkg::OP_JAL) || (opcode == fetch_pkg::OP_JALR) ||
                     (opcode == fetch_pkg::OP_BRANCH) || (opcode == fetch_pkg::OP_SYSTEM);
  assign is_load   = (opcode == fetch_pkg::OP_LOAD);
  assign is_store  = (opcode == fetch_pkg::OP_STORE);
  assign is_fence  = (cache_inst_i == fetch_pkg::INST_FENCE_I);

  assign pc_seq      = pc_q + 32'd4;
  assign retire_next = retire_pc_i + 32'd4;

  // speculation outcome
  assign spec_open  = (spec_q == fetch_pkg::SPEC);
  assign resolve    = spec_open && (pc_change_i || pc_retire_i);
  assign pred_match = pc_change_i ? (npc_i == pred_q) : (retire_next == pred_q);
  assign resolve_good = resolve && pred_match;
  assign resolve_bad  = resolve && !pred_match;

  // memory ops wait until the speculation is settled
  assign valid_o = hit_i && !hazard_q && !redir_q && !resolve_bad &&
                   !(spec_open && (is_load || is_store));

  assign xfer       = valid_o && ready_i;
  assign start_spec = xfer && is_branch && btb_valid_q && !spec_open;
  assign release_hz = hazard_q && !spec_open && !redir_q && (pc_change_i || pc_retire_i);
  assign resume     = redir_q && idle_i;

  assign fetch_pc_o = pc_q;
  assign pc_o       = pc_q;
  assign inst_o     = cache_inst_i;
  assign flush_o    = xfer && is_fence;

  assign spec_o      = spec_open;
  assign good_spec_o = (spec_q == fetch_pkg::GOOD);
  assign bad_spec_o  = (spec_q == fetch_pkg::BAD);

  always_comb begin
    spec_d = spec_q;
    case (spec_q)
      fetch_pkg::NONE: begin
        if (start_spec) begin
          spec_d = fetch_pkg::SPEC;
        end
      end
      fetch_pkg::SPEC: begin
        if (resolve_good) begin
          spec_d = fetch_pkg::GOOD;
        end else if (resolve_bad) begin
          spec_d = fetch_pkg::BAD;
        end
      end
      // one-cycle pulse states
      fetch_pkg::GOOD, fetch_pkg::BAD: begin
        spec_d = start_spec ? fetch_pkg::SPEC : fetch_pkg::NONE;
      end
      default: begin
        spec_d = fetch_pkg::NONE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      spec_q <= fetch_pkg::NONE;
    end else begin
      spec_q <= spec_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= fetch_pkg::PC_INIT;
    end else if (resume) begin
      pc_q <= redir_pc_q;
    end else if (release_hz) begin
      pc_q <= pc_change_i ? npc_i : pc_seq;
    end else if (start_spec) begin
      pc_q <= btb_q;
    end else if (xfer && !is_branch && !is_load && !is_fence) begin
      pc_q <= pc_seq;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hazard_q <= 1'b0;
    end else if (resume || release_hz) begin
      hazard_q <= 1'b0;
    end else if (xfer && (is_load || is_fence || (is_branch && !start_spec))) begin
      hazard_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      redir_q <= 1'b0;
    end else if (resolve_bad) begin
      redir_q <= 1'b1;
    end else if (resume) begin
      redir_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      btb_valid_q <= 1'b0;
    end else if (pc_change_i) begin
      btb_valid_q <= 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (pc_change_i) begin
      btb_q <= npc_i;
    end
    if (start_spec) begin
      pred_q <= btb_q;
      fall_q <= pc_seq;
    end
    if (resolve_bad) begin
      redir_pc_q <= pc_change_i ? npc_i : fall_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [26:0] tag_t;
  typedef logic [1:0]  idx_t;

  // cache geometry
  localparam int L1I_SETS       = 4;
  localparam int L1I_LINE_WORDS = 2;
  localparam int L1I_IDX_W      = $clog2(L1I_SETS);
  localparam int L1I_OFF_W      = $clog2(L1I_LINE_WORDS);
  localparam int L1I_OFF_LSB    = 2;
  localparam int L1I_IDX_LSB    = L1I_OFF_LSB + L1I_OFF_W;
  localparam int L1I_TAG_LSB    = L1I_IDX_LSB + L1I_IDX_W;

  localparam addr_t PC_INIT = 32'h8000_0000;

  // rv32i major opcodes
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  localparam word_t INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [2:0] {
    IDLE,
    FILL0,
    GAP,
    FILL1,
    DONE
  } icache_state_t;

  typedef enum logic [1:0] {
    NONE,
    SPEC,
    GOOD,
    BAD
  } spec_state_t;

endpackage

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  wire                      clk,
  input  wire                      rst,
  output fetch_pkg::addr_t         araddr_o,
  output logic                     arvalid_o,
  input  wire fetch_pkg::word_t    rdata_i,
  input  wire                      rvalid_i,
  output fetch_pkg::word_t         inst_o,
  output fetch_pkg::addr_t         pc_o,
  output logic                     valid_o,
  input  wire                      ready_i,
  input  wire                      pc_change_i,
  input  wire fetch_pkg::addr_t    npc_i,
  input  wire                      pc_retire_i,
  input  wire fetch_pkg::addr_t    retire_pc_i,
  output logic                     spec_o,
  output logic                     good_spec_o,
  output logic                     bad_spec_o
);

  fetch_pkg::addr_t fetch_pc;
  fetch_pkg::word_t cache_inst;
  logic             flush;
  logic             hit;
  logic             idle;

  fetch_ctrl i_fetch_ctrl (
    .clk          (clk),
    .rst          (rst),
    .cache_inst_i (cache_inst),
    .hit_i        (hit),
    .idle_i       (idle),
    .fetch_pc_o   (fetch_pc),
    .flush_o      (flush),
    .inst_o       (inst_o),
    .pc_o         (pc_o),
    .valid_o      (valid_o),
    .ready_i      (ready_i),
    .pc_change_i  (pc_change_i),
    .npc_i        (npc_i),
    .pc_retire_i  (pc_retire_i),
    .retire_pc_i  (retire_pc_i),
    .spec_o       (spec_o),
    .good_spec_o  (good_spec_o),
    .bad_spec_o   (bad_spec_o)
  );

  icache_l1 i_icache_l1 (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc),
    .flush_i      (flush),
    .cache_inst_o (cache_inst),
    .hit_o        (hit),
    .idle_o       (idle),
    .araddr_o     (araddr_o),
    .arvalid_o    (arvalid_o),
    .rdata_i      (rdata_i),
    .rvalid_i     (rvalid_i)
  );

endmodule

`default_nettype wire

// ==== source/icache_l1.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_l1 (
  input  wire                      clk,
  input  wire                      rst,
  input  wire fetch_pkg::addr_t    fetch_pc_i,
  input  wire                      flush_i,
  output fetch_pkg::word_t         cache_inst_o,
  output logic                     hit_o,
  output logic                     idle_o,
  output fetch_pkg::addr_t         araddr_o,
  output logic                     arvalid_o,
  input  wire fetch_pkg::word_t    rdata_i,
  input  wire                      rvalid_i
);

  fetch_pkg::word_t line_data [fetch_pkg::L1I_SETS][fetch_pkg::L1I_LINE_WORDS];
  fetch_pkg::tag_t  line_tag  [fetch_pkg::L1I_SETS];
  logic [fetch_pkg::L1I_SETS-1:0] line_valid;

  fetch_pkg::icache_state_t state_q;

  // line under fill as latched on the miss
  fetch_pkg::tag_t fill_tag_q;
  fetch_pkg::idx_t fill_idx_q;
  logic            fill_beat;

  fetch_pkg::tag_t                 pc_tag;
  fetch_pkg::idx_t                 pc_idx;
  logic [fetch_pkg::L1I_OFF_W-1:0] pc_off;
  logic                            lookup_ok;

  assign pc_tag = fetch_pc_i[31:fetch_pkg::L1I_TAG_LSB];
  assign pc_idx = fetch_pc_i[fetch_pkg::L1I_TAG_LSB-1:fetch_pkg::L1I_IDX_LSB];
  assign pc_off = fetch_pc_i[fetch_pkg::L1I_IDX_LSB-1:fetch_pkg::L1I_OFF_LSB];

  // lookups only count outside of a fill
  assign lookup_ok = (state_q == fetch_pkg::IDLE) || (state_q == fetch_pkg::DONE);

  assign hit_o = lookup_ok && line_valid[pc_idx] && (line_tag[pc_idx] == pc_tag);
  assign cache_inst_o = line_data[pc_idx][pc_off];
  assign idle_o = (state_q == fetch_pkg::IDLE);

  // even word first, then odd word
  assign fill_beat = (state_q == fetch_pkg::FILL1);
  assign araddr_o  = {fill_tag_q, fill_idx_q, fill_beat, 2'b00};
  assign arvalid_o = (state_q == fetch_pkg::FILL0) || (state_q == fetch_pkg::FILL1);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= fetch_pkg::IDLE;
    end else begin
      case (state_q)
        fetch_pkg::IDLE: begin
          if (!hit_o) begin
            state_q <= fetch_pkg::FILL0;
          end
        end
        fetch_pkg::FILL0: begin
          if (rvalid_i) begin
            state_q <= fetch_pkg::GAP;
          end
        end
        fetch_pkg::GAP: begin
          state_q <= fetch_pkg::FILL1;
        end
        fetch_pkg::FILL1: begin
          if (rvalid_i) begin
            state_q <= fetch_pkg::DONE;
          end
        end
        fetch_pkg::DONE: begin
          state_q <= fetch_pkg::IDLE;
        end
        default: begin
          state_q <= fetch_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
    end else if (flush_i) begin
      line_valid <= '0;
    end else if ((state_q == fetch_pkg::FILL1) && rvalid_i) begin
      line_valid[fill_idx_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == fetch_pkg::IDLE) && !hit_o) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
  end

  // line storage
  always_ff @(posedge clk) begin
    if ((state_q == fetch_pkg::FILL0) && rvalid_i) begin
      line_data[fill_idx_q][0] <= rdata_i;
    end
    if ((state_q == fetch_pkg::FILL1) && rvalid_i) begin
      line_data[fill_idx_q][1] <= rdata_i;
      line_tag[fill_idx_q]     <= fill_tag_q;
    end
  end

endmodule

`default_nettype wire

// ==== tb/imem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_model (
  input  wire                      clk,
  input  wire                      rst,
  input  wire fetch_pkg::addr_t    araddr_i,
  input  wire                      arvalid_i,
  output fetch_pkg::word_t         rdata_o,
  output logic                     rvalid_o,
  output logic [31:0]              req_count_o
);

  localparam int LATENCY = 2;
  localparam int DEPTH   = 64;

  // program image written by the testbench
  fetch_pkg::word_t mem [DEPTH];

  logic             busy_q;
  logic [1:0]       wait_q;
  fetch_pkg::addr_t addr_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      wait_q      <= '0;
      rvalid_o    <= 1'b0;
      req_count_o <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if (busy_q) begin
        if (wait_q == '0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[addr_q[7:2]];
          busy_q   <= 1'b0;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end else if (arvalid_i && !rvalid_o) begin
        // one count per address phase
        busy_q      <= 1'b1;
        wait_q      <= 2'(LATENCY - 1);
        addr_q      <= araddr_i;
        req_count_o <= req_count_o + 32'd1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

  typedef enum logic [1:0] {RESP_NONE, RESP_CHANGE, RESP_RETIRE} resp_t;
  typedef enum logic [1:0] {PULSE_NONE, PULSE_GOOD, PULSE_BAD} pulse_t;

  typedef struct {
    fetch_pkg::addr_t pc;
    fetch_pkg::word_t inst;
    int unsigned      stall;
    resp_t            resp;
    fetch_pkg::addr_t target;
    logic             spec;
    pulse_t           pulse;
    logic             req;
  } step_t;

  localparam int PROG_WORDS = 7;

  logic             clk = 1'b0;
  logic             rst;
  fetch_pkg::addr_t araddr;
  logic             arvalid;
  fetch_pkg::word_t rdata;
  logic             rvalid;
  fetch_pkg::word_t inst;
  fetch_pkg::addr_t pc;
  logic             valid;
  logic             ready;
  logic             pc_change;
  fetch_pkg::addr_t npc;
  logic             pc_retire;
  fetch_pkg::addr_t retire_pc;
  logic             spec;
  logic             good_spec;
  logic             bad_spec;
  logic [31:0]      req_count;

  fetch_pkg::word_t prog [PROG_WORDS];
  step_t            steps [$];
  logic [31:0]      rand_state;
  logic [31:0]      req_base;
  int unsigned      cycles = 0;
  int unsigned      cycle_limit = 0;

  // read bus monitor state
  fetch_pkg::addr_t bus_addr_q;
  logic             bus_wait_q = 1'b0;
  logic             bus_odd_q  = 1'b0;

  always #2 clk = ~clk;

  fetch_top i_fetch_top (
    .clk (clk), .rst (rst),
    .araddr_o (araddr), .arvalid_o (arvalid), .rdata_i (rdata), .rvalid_i (rvalid),
    .inst_o (inst), .pc_o (pc), .valid_o (valid), .ready_i (ready),
    .pc_change_i (pc_change), .npc_i (npc),
    .pc_retire_i (pc_retire), .retire_pc_i (retire_pc),
    .spec_o (spec), .good_spec_o (good_spec), .bad_spec_o (bad_spec)
  );

  imem_model i_imem (
    .clk (clk), .rst (rst),
    .araddr_i (araddr), .arvalid_i (arvalid), .rdata_o (rdata), .rvalid_o (rvalid),
    .req_count_o (req_count)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  // address held until its beat returns, even word before odd word
  always @(negedge clk) begin
    if ((rst === 1'b0) && (bus_wait_q || (arvalid === 1'b1))) begin
      check_flag("arvalid_o held until rvalid_i", arvalid, 1'b1);
      if (bus_wait_q) begin
        check_addr("araddr_o held until rvalid_i", araddr, bus_addr_q);
      end else if (bus_odd_q) begin
        check_addr("araddr_o odd word of the line", araddr, bus_addr_q + 32'd4);
      end else begin
        check_flag("araddr_o even word first", araddr[2:0] == 3'b000, 1'b1);
      end
      bus_addr_q = araddr;
      bus_wait_q = (rvalid !== 1'b1);
      if (rvalid === 1'b1) begin
        bus_odd_q = !bus_odd_q;
      end
    end
  end

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_addr(input string what, input fetch_pkg::addr_t got,
                            input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_word(input string what, input fetch_pkg::word_t got,
                            input fetch_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic load_program();
    int i;
    prog[0] = 32'h0010_0093;  // addi x1, x0, 1
    prog[1] = 32'h0001_0663;  // beq x2, x0, +12
    prog[2] = 32'h0000_a183;  // lw x3, 0(x1)
    prog[3] = 32'hff5f_f06f;  // jal x0, -12
    prog[4] = 32'h0000_100f;  // fence.i
    prog[5] = 32'h0050_0213;  // addi x4, x0, 5
    prog[6] = 32'h0060_0293;  // addi x5, x0, 6
    // addi x0 with the word index as immediate
    for (i = 0; i < 64; i++) begin
      i_imem.mem[i] = {12'(i), 20'h00013};
    end
    for (i = 0; i < PROG_WORDS; i++) begin
      i_imem.mem[i] = prog[i];
    end
  endtask

  task automatic add_step(input int idx, input resp_t resp, input int tgt_idx,
                          input logic exp_spec, input pulse_t pulse, input logic req);
    step_t s;
    rand_state = next_rand(rand_state);
    s.pc     = fetch_pkg::PC_INIT + 32'(idx * 4);
    s.inst   = prog[idx];
    s.stall  = rand_state >> 30;
    s.resp   = resp;
    s.target = fetch_pkg::PC_INIT + 32'(tgt_idx * 4);
    s.spec   = exp_spec;
    s.pulse  = pulse;
    s.req    = req;
    steps.push_back(s);
  endtask

  task automatic build_table();
    rand_state = 32'h7270_0fc5;
    // first pass stalls on every branch with the btb empty
    add_step(0, RESP_NONE,   0, 1'b0, PULSE_NONE, 1'b1);
    add_step(1, RESP_RETIRE, 0, 1'b0, PULSE_NONE, 1'b0);
    add_step(2, RESP_RETIRE, 0, 1'b0, PULSE_NONE, 1'b1);
    add_step(3, RESP_CHANGE, 0, 1'b0, PULSE_NONE, 1'b0);
    // second pass runs from the cache with btb at word 0
    add_step(0, RESP_NONE,   0, 1'b0, PULSE_NONE, 1'b0);
    add_step(1, RESP_RETIRE, 0, 1'b1, PULSE_BAD,  1'b0);
    add_step(2, RESP_RETIRE, 0, 1'b0, PULSE_NONE, 1'b0);
    add_step(3, RESP_CHANGE, 0, 1'b1, PULSE_GOOD, 1'b0);
    // third pass leaves through the beq
    add_step(0, RESP_NONE,   0, 1'b0, PULSE_NONE, 1'b0);
    add_step(1, RESP_CHANGE, 4, 1'b1, PULSE_BAD,  1'b0);
    add_step(4, RESP_RETIRE, 0, 1'b0, PULSE_NONE, 1'b1);
    // line 2 again after the flush, then line 3
    add_step(5, RESP_NONE,   0, 1'b0, PULSE_NONE, 1'b1);
    add_step(6, RESP_NONE,   0, 1'b0, PULSE_NONE, 1'b1);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] delta;
    logic        hazard;
    while (valid !== 1'b1) begin
      @(negedge clk);
    end
    delta = req_count - req_base;
    check_flag("bus request", delta != 0, s.req);
    if (s.req) begin
      check_flag("two requests per line fill", delta == 2, 1'b1);
    end
    check_addr("pc_o", pc, s.pc);
    check_word("inst_o", inst, s.inst);
    repeat (s.stall) begin
      @(negedge clk);
      check_flag("valid_o under back-pressure", valid, 1'b1);
      check_addr("pc_o under back-pressure", pc, s.pc);
      check_word("inst_o under back-pressure", inst, s.inst);
    end
    req_base = req_count;
    ready = 1'b1;
    @(negedge clk);
    ready = 1'b0;
    check_flag("spec_o", spec, s.spec);
    hazard = (s.resp != RESP_NONE) && !s.spec;
    if (hazard) begin
      repeat (3) begin
        check_flag("valid_o during hazard", valid, 1'b0);
        @(negedge clk);
      end
    end
    // execute stage answer
    if (s.resp != RESP_NONE) begin
      pc_change = (s.resp == RESP_CHANGE);
      pc_retire = (s.resp == RESP_RETIRE);
      npc       = s.target;
      retire_pc = s.pc;
      @(negedge clk);
      pc_change = 1'b0;
      pc_retire = 1'b0;
    end
    check_flag("good_spec_o", good_spec, s.pulse == PULSE_GOOD);
    check_flag("bad_spec_o", bad_spec, s.pulse == PULSE_BAD);
    // pulses last a single cycle
    if (s.pulse != PULSE_NONE) begin
      @(negedge clk);
      check_flag("good_spec_o one cycle later", good_spec, 1'b0);
      check_flag("bad_spec_o one cycle later", bad_spec, 1'b0);
    end
  endtask

  initial begin
    int i;
    rst       = 1'b1;
    ready     = 1'b0;
    pc_change = 1'b0;
    npc       = '0;
    pc_retire = 1'b0;
    retire_pc = '0;
    req_base  = '0;
    load_program();
    build_table();
    cycle_limit = 64 * steps.size();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_flag("valid_o after reset", valid, 1'b0);
    check_flag("arvalid_o after reset", arvalid, 1'b0);
    check_flag("spec_o after reset", spec, 1'b0);
    check_flag("good_spec_o after reset", good_spec, 1'b0);
    check_flag("bad_spec_o after reset", bad_spec, 1'b0);
    for (i = 0; i < steps.size(); i++) begin
      run_step(steps[i]);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire
